//--- mem_hier.f
verilog/mem_hier_pkg.sv
verilog/mem_word_adapter.sv
verilog/line_cache.sv
verilog/cache_arbiter.sv
verilog/cacheline_adaptor.sv
verilog/mem_hier.sv
sim/burst_mem_model.sv
sim/mem_hier_props.sv
sim/mem_hier_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mem_hier_tb \
    -f mem_hier.f -o mem_hier_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mem_hier_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -Fxq "Simulation completed successfully"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- sim/mem_hier_tb.sv
`timescale 1ns/100ps

module mem_hier_tb;

    localparam int SETS           = 8;
    localparam int SHADOW_WORDS   = 512;      // data region 0x000 to 0x7ff
    localparam int TIMEOUT_CYCLES = 15000;

    logic                      clk = 1'b0;
    logic                      rst_n_i;
    mem_hier_pkg::word_t       imem_addr_i;
    logic                      imem_read_i;
    mem_hier_pkg::word_t       imem_rdata_o;
    logic                      imem_resp_o;
    mem_hier_pkg::word_t       dmem_addr_i;
    logic                      dmem_read_i;
    logic                      dmem_write_i;
    mem_hier_pkg::byte_mask_t  dmem_wmask_i;
    mem_hier_pkg::word_t       dmem_wdata_i;
    mem_hier_pkg::word_t       dmem_rdata_o;
    logic                      dmem_resp_o;
    mem_hier_pkg::word_t       bmem_addr_o;
    logic                      bmem_read_o;
    logic                      bmem_write_o;
    mem_hier_pkg::burst_t      bmem_wdata_o;
    mem_hier_pkg::burst_t      bmem_rdata_i;
    logic                      bmem_resp_i;

    mem_hier_pkg::word_t       shadow [SHADOW_WORDS];
    logic [31:0]               lcg_state = 32'h4fbb;
    int                        error_count = 0;
    int                        check_count = 0;
    int                        cycle_count = 0;

    always #4 clk = ~clk;   // 8 ns period

    mem_hier #(.SETS(SETS)) u_mem_hier (.*);

    burst_mem_model #(.LATENCY(3)) u_bmem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (bmem_addr_o),
        .read_i  (bmem_read_o),
        .write_i (bmem_write_o),
        .wdata_i (bmem_wdata_o),
        .rdata_o (bmem_rdata_i),
        .resp_o  (bmem_resp_i)
    );

    bind mem_hier mem_hier_props u_props (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .imem_read_i  (imem_read_i),
        .imem_resp_o  (imem_resp_o),
        .dmem_read_i  (dmem_read_i),
        .dmem_write_i (dmem_write_i),
        .dmem_resp_o  (dmem_resp_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o)
    );

    // same hash the memory model preloads with
    function automatic mem_hier_pkg::word_t preload_value(input logic [31:0] word_addr);
        logic [31:0] h;
        h = word_addr * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ 32'h5bd1_e995;
        return h;
    endfunction

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic mem_hier_pkg::word_t merge_bytes(input mem_hier_pkg::word_t old_w,
            input mem_hier_pkg::word_t new_w, input mem_hier_pkg::byte_mask_t mask);
        mem_hier_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string what, input mem_hier_pkg::word_t addr,
            input mem_hier_pkg::word_t got, input mem_hier_pkg::word_t exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("** Error at %0t ns: %s at 0x%08h returned 0x%08h, expected 0x%08h",
                     $time, what, addr, got, exp);
        end
    endtask

    task automatic fetch_word(input mem_hier_pkg::word_t addr,
            output mem_hier_pkg::word_t data);
        @(posedge clk);
        imem_addr_i <= addr;
        imem_read_i <= 1'b1;
        do begin
            @(negedge clk);
        end while (!imem_resp_o);
        data = imem_rdata_o;
        @(posedge clk);
        imem_read_i <= 1'b0;
    endtask

    task automatic load_word(input mem_hier_pkg::word_t addr,
            output mem_hier_pkg::word_t data);
        @(posedge clk);
        dmem_addr_i <= addr;
        dmem_read_i <= 1'b1;
        do begin
            @(negedge clk);
        end while (!dmem_resp_o);
        data = dmem_rdata_o;
        @(posedge clk);
        dmem_read_i <= 1'b0;
    endtask

    task automatic store_word(input mem_hier_pkg::word_t addr,
            input mem_hier_pkg::word_t data, input mem_hier_pkg::byte_mask_t mask);
        @(posedge clk);
        dmem_addr_i  <= addr;
        dmem_wdata_i <= data;
        dmem_wmask_i <= mask;
        dmem_write_i <= 1'b1;
        do begin
            @(negedge clk);
        end while (!dmem_resp_o);
        @(posedge clk);
        dmem_write_i <= 1'b0;
        shadow[addr[10:2]] = merge_bytes(shadow[addr[10:2]], data, mask);
    endtask

    task automatic idle_outputs_stay_low();
        repeat (16) begin
            @(negedge clk);
            check_count++;
            assert (!imem_resp_o && !dmem_resp_o && !bmem_read_o && !bmem_write_o) else begin
                error_count++;
                $display("** Error at %0t ns: resp or burst strobe high with no request",
                         $time);
            end
        end
    endtask

    task automatic fetch_preloaded_lines();
        mem_hier_pkg::word_t addr;
        mem_hier_pkg::word_t data;
        for (int i = 0; i < 12; i++) begin
            addr = 32'h800 + 32'(i) * 32'h64;   // crosses lines and sets
            fetch_word(addr, data);
            check_word("fetch", addr, data, preload_value(addr >> 2));
            fetch_word(addr, data);
            check_word("refetch", addr, data, preload_value(addr >> 2));
        end
    endtask

    task automatic store_partial_bytes();
        mem_hier_pkg::word_t addr;
        mem_hier_pkg::word_t data;
        addr = 32'h0000_0014;
        load_word(addr, data);
        check_word("load before store", addr, data, shadow[addr[10:2]]);
        store_word(addr, 32'ha5c3_7e19, 4'b0101);
        load_word(addr, data);
        check_word("load after masked store", addr, data, shadow[addr[10:2]]);
        store_word(addr, 32'h6b00_0000, 4'b1000);
        load_word(addr, data);
        check_word("load after top byte store", addr, data, shadow[addr[10:2]]);
    endtask

    task automatic evict_dirty_line();
        mem_hier_pkg::word_t a;
        mem_hier_pkg::word_t b;
        mem_hier_pkg::word_t data;
        a = 32'h0000_0048;
        store_word(a, 32'h1234_5678, 4'hf);
        b = a + 32'(SETS * 32);             // same set, other tag
        load_word(b, data);
        check_word("conflict load", b, data, shadow[b[10:2]]);
        b = a + 32'(2 * SETS * 32);
        load_word(b, data);
        check_word("second conflict load", b, data, shadow[b[10:2]]);
        load_word(a, data);                 // refill after write-back
        check_word("reload evicted line", a, data, shadow[a[10:2]]);
    endtask

    task automatic miss_on_both_ports();
        mem_hier_pkg::word_t iword;
        mem_hier_pkg::word_t dword;
        fork
            fetch_word(32'h0000_0e80, iword);
            load_word(32'h0000_07e0, dword);
        join
        check_word("parallel fetch", 32'h0000_0e80, iword, preload_value(32'h0000_0e80 >> 2));
        check_word("parallel load", 32'h0000_07e0, dword, shadow[9'h1f8]);
    endtask

    task automatic random_load_store();
        logic [31:0]               r;
        mem_hier_pkg::word_t       addr;
        mem_hier_pkg::word_t       data;
        mem_hier_pkg::byte_mask_t  mask;
        for (int n = 0; n < 200; n++) begin
            r    = next_random();
            addr = {22'd0, r[23:16], 2'b00};   // 1 KiB window
            mask = (r[27:24] == 4'd0) ? 4'hf : r[27:24];
            if (r[31]) begin
                store_word(addr, next_random(), mask);
            end else begin
                load_word(addr, data);
                check_word("random load", addr, data, shadow[addr[10:2]]);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no handshake finished within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst_n_i      = 1'b0;
        imem_addr_i  = '0;
        imem_read_i  = 1'b0;
        dmem_addr_i  = '0;
        dmem_read_i  = 1'b0;
        dmem_write_i = 1'b0;
        dmem_wmask_i = '0;
        dmem_wdata_i = '0;
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow[i] = preload_value(32'(i));
        end
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;

        idle_outputs_stay_low();
        fetch_preloaded_lines();
        store_partial_bytes();
        evict_dirty_line();
        miss_on_both_ports();
        random_load_store();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : mem_hier_tb

//--- sim/mem_hier_props.sv
`timescale 1ns/100ps

module mem_hier_props (
    input logic clk,
    input logic rst_n_i,
    input logic imem_read_i,
    input logic imem_resp_o,
    input logic dmem_read_i,
    input logic dmem_write_i,
    input logic dmem_resp_o,
    input logic bmem_read_o,
    input logic bmem_write_o
);

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(bmem_read_o && bmem_write_o))
        else $error("burst read and write strobes high in the same cycle");

    imem_resp_with_read: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(imem_resp_o) |-> imem_read_i)
        else $error("instruction resp rose without a read request");

    dmem_resp_with_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(dmem_resp_o) |-> (dmem_read_i || dmem_write_i))
        else $error("data resp rose without a read or write request");

    strobes_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (!bmem_read_o && !bmem_write_o))
        else $error("burst strobe high right after reset release");

endmodule : mem_hier_props

//--- sim/burst_mem_model.sv
`timescale 1ns/100ps

module burst_mem_model #(
    parameter int LATENCY = 3
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  mem_hier_pkg::word_t   addr_i,     // line aligned, held for all four beats
    input  logic                  read_i,
    input  logic                  write_i,
    input  mem_hier_pkg::burst_t  wdata_i,
    output mem_hier_pkg::burst_t  rdata_o,
    output logic                  resp_o
);

    localparam int WORDS = 1024;   // 4 KiB

    mem_hier_pkg::word_t  mem [WORDS];
    logic [1:0]           beat_q;
    logic [3:0]           wait_q;
    logic [9:0]           widx;

    // content at reset depends on every bit of the word address
    function automatic mem_hier_pkg::word_t memory_hash(input logic [31:0] word_addr);
        logic [31:0] h;
        h = word_addr * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ 32'h5bd1_e995;
        return h;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = memory_hash(32'(i));
        end
    end

    // two words per beat, lowest address first
    assign widx = addr_i[11:2] + {7'd0, beat_q, 1'b0};

    always @(posedge clk) begin
        resp_o <= 1'b0;
        if (!rst_n_i || !(read_i || write_i)) begin
            beat_q <= '0;
            wait_q <= '0;
        end else if (resp_o) begin
            // beat accepted this cycle
            if (write_i) begin
                mem[widx]         <= wdata_i[31:0];
                mem[widx + 10'd1] <= wdata_i[63:32];
            end
            beat_q <= beat_q + 2'd1;
            wait_q <= '0;
        end else if (wait_q == 4'(LATENCY - 1)) begin
            resp_o  <= 1'b1;
            rdata_o <= {mem[widx + 10'd1], mem[widx]};
        end else begin
            wait_q <= wait_q + 4'd1;
        end
    end

endmodule : burst_mem_model

//--- verilog/mem_hier.sv
`timescale 1ns/100ps

module mem_hier #(
    parameter int SETS = 8
) (
    input  logic                      clk,
    input  logic                      rst_n_i,

    // instruction fetch port
    input  mem_hier_pkg::word_t       imem_addr_i,
    input  logic                      imem_read_i,
    output mem_hier_pkg::word_t       imem_rdata_o,
    output logic                      imem_resp_o,

    // data port
    input  mem_hier_pkg::word_t       dmem_addr_i,
    input  logic                      dmem_read_i,
    input  logic                      dmem_write_i,
    input  mem_hier_pkg::byte_mask_t  dmem_wmask_i,
    input  mem_hier_pkg::word_t       dmem_wdata_i,
    output mem_hier_pkg::word_t       dmem_rdata_o,
    output logic                      dmem_resp_o,

    // burst memory port
    output mem_hier_pkg::word_t       bmem_addr_o,
    output logic                      bmem_read_o,
    output logic                      bmem_write_o,
    output mem_hier_pkg::burst_t      bmem_wdata_o,
    input  mem_hier_pkg::burst_t      bmem_rdata_i,
    input  logic                      bmem_resp_i
);

    // adapter <-> cache
    mem_hier_pkg::line_t       icache_rdata, dcache_rdata;
    mem_hier_pkg::line_t       imem_line_wdata, dmem_line_wdata;
    mem_hier_pkg::line_mask_t  imem_line_mask, dmem_line_mask;

    // cache <-> arbiter <-> adaptor
    mem_hier_pkg::line_req_t   icache_req, dcache_req, mem_req;
    mem_hier_pkg::line_t       icache_line, dcache_line, mem_line;
    logic                      icache_line_resp, dcache_line_resp, mem_resp;

    mem_word_adapter u_imem_adapter (
        .addr_i       (imem_addr_i),
        .line_rdata_i (icache_rdata),
        .wdata_i      ('0),           // fetch never stores
        .wmask_i      ('0),
        .rdata_o      (imem_rdata_o),
        .line_wdata_o (imem_line_wdata),
        .line_mask_o  (imem_line_mask)
    );

    mem_word_adapter u_dmem_adapter (
        .addr_i       (dmem_addr_i),
        .line_rdata_i (dcache_rdata),
        .wdata_i      (dmem_wdata_i),
        .wmask_i      (dmem_wmask_i),
        .rdata_o      (dmem_rdata_o),
        .line_wdata_o (dmem_line_wdata),
        .line_mask_o  (dmem_line_mask)
    );

    line_cache #(.SETS(SETS), .WRITABLE(0)) u_icache (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .addr_i      (imem_addr_i),
        .read_i      (imem_read_i),
        .write_i     (1'b0),
        .wdata_i     (imem_line_wdata),
        .mask_i      (imem_line_mask),
        .rdata_o     (icache_rdata),
        .resp_o      (imem_resp_o),
        .req_o       (icache_req),
        .line_i      (icache_line),
        .line_resp_i (icache_line_resp)
    );

    line_cache #(.SETS(SETS), .WRITABLE(1)) u_dcache (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .addr_i      (dmem_addr_i),
        .read_i      (dmem_read_i),
        .write_i     (dmem_write_i),
        .wdata_i     (dmem_line_wdata),
        .mask_i      (dmem_line_mask),
        .rdata_o     (dcache_rdata),
        .resp_o      (dmem_resp_o),
        .req_o       (dcache_req),
        .line_i      (dcache_line),
        .line_resp_i (dcache_line_resp)
    );

    cache_arbiter u_arbiter (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .icache_req_i  (icache_req),
        .icache_line_o (icache_line),
        .icache_resp_o (icache_line_resp),
        .dcache_req_i  (dcache_req),
        .dcache_line_o (dcache_line),
        .dcache_resp_o (dcache_line_resp),
        .mem_req_o     (mem_req),
        .mem_line_i    (mem_line),
        .mem_resp_i    (mem_resp)
    );

    cacheline_adaptor u_adaptor (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (mem_req),
        .line_o       (mem_line),
        .resp_o       (mem_resp),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule : mem_hier

//--- verilog/cacheline_adaptor.sv
`timescale 1ns/100ps

module cacheline_adaptor (
    input  logic                     clk,
    input  logic                     rst_n_i,

    // line side
    input  mem_hier_pkg::line_req_t  req_i,
    output mem_hier_pkg::line_t      line_o,
    output logic                     resp_o,

    // burst memory
    output mem_hier_pkg::word_t      bmem_addr_o,
    output logic                     bmem_read_o,
    output logic                     bmem_write_o,
    output mem_hier_pkg::burst_t     bmem_wdata_o,
    input  mem_hier_pkg::burst_t     bmem_rdata_i,
    input  logic                     bmem_resp_i
);

    localparam int CNT_BITS  = $clog2(mem_hier_pkg::BEATS_PER_LINE);
    localparam int BEAT_BITS = $bits(mem_hier_pkg::burst_t);
    localparam int LINE_BITS = $bits(mem_hier_pkg::line_t);

    typedef enum logic [1:0] {
        AD_IDLE,
        AD_READ,
        AD_WRITE,
        AD_DONE
    } ad_state_e;

    ad_state_e              state_q;
    logic [CNT_BITS-1:0]    beat_q;
    logic                   last_beat;
    logic                   busy;

    mem_hier_pkg::word_t    addr_q;
    mem_hier_pkg::line_t    line_q;    // shift register, low beat first

    assign busy      = (state_q == AD_READ) || (state_q == AD_WRITE);
    assign last_beat = bmem_resp_i &&
                       (beat_q == CNT_BITS'(mem_hier_pkg::BEATS_PER_LINE - 1));

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state_q == AD_READ);
    assign bmem_write_o = (state_q == AD_WRITE);
    assign bmem_wdata_o = line_q[BEAT_BITS-1:0];
    assign line_o       = line_q;
    assign resp_o       = (state_q == AD_DONE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= AD_IDLE;
            beat_q  <= '0;
        end else begin
            unique case (state_q)
                AD_IDLE: begin
                    beat_q <= '0;
                    if (req_i.write) begin
                        state_q <= AD_WRITE;
                    end else if (req_i.read) begin
                        state_q <= AD_READ;
                    end
                end
                AD_READ,
                AD_WRITE: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= AD_DONE;   // strobe drops here
                    end
                end
                AD_DONE: state_q <= AD_IDLE;
                default: state_q <= AD_IDLE;
            endcase
        end
    end

    // one shift serves both directions
    // reads fill from the top, writes drain from the bottom
    always_ff @(posedge clk) begin
        if (state_q == AD_IDLE) begin
            addr_q <= req_i.addr;
            line_q <= req_i.wdata;
        end else if (busy && bmem_resp_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

endmodule : cacheline_adaptor

//--- verilog/cache_arbiter.sv
`timescale 1ns/100ps

module cache_arbiter (
    input  logic                     clk,
    input  logic                     rst_n_i,

    // instruction cache
    input  mem_hier_pkg::line_req_t  icache_req_i,
    output mem_hier_pkg::line_t      icache_line_o,
    output logic                     icache_resp_o,

    // data cache
    input  mem_hier_pkg::line_req_t  dcache_req_i,
    output mem_hier_pkg::line_t      dcache_line_o,
    output logic                     dcache_resp_o,

    // cacheline adaptor
    output mem_hier_pkg::line_req_t  mem_req_o,
    input  mem_hier_pkg::line_t      mem_line_i,
    input  logic                     mem_resp_i
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SERVE_I,
        ARB_SERVE_D
    } arb_state_e;

    arb_state_e state_q;

    logic icache_pending;
    logic dcache_pending;

    assign icache_pending = icache_req_i.read || icache_req_i.write;
    assign dcache_pending = dcache_req_i.read || dcache_req_i.write;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            unique case (state_q)
                ARB_IDLE: begin
                    if (dcache_pending) begin
                        state_q <= ARB_SERVE_D;   // data wins ties
                    end else if (icache_pending) begin
                        state_q <= ARB_SERVE_I;
                    end
                end
                ARB_SERVE_I,
                ARB_SERVE_D: begin
                    if (mem_resp_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // route the granted request down and the response back
    always_comb begin
        mem_req_o     = '0;
        icache_line_o = '0;
        icache_resp_o = 1'b0;
        dcache_line_o = '0;
        dcache_resp_o = 1'b0;
        if (state_q == ARB_SERVE_I) begin
            mem_req_o     = icache_req_i;
            icache_line_o = mem_line_i;
            icache_resp_o = mem_resp_i;
        end else if (state_q == ARB_SERVE_D) begin
            mem_req_o     = dcache_req_i;
            dcache_line_o = mem_line_i;
            dcache_resp_o = mem_resp_i;
        end
    end

endmodule : cache_arbiter

//--- verilog/line_cache.sv
`timescale 1ns/100ps

module line_cache #(
    parameter int SETS     = 8,
    parameter int WRITABLE = 1
) (
    input  logic                       clk,
    input  logic                       rst_n_i,

    // core side, held until resp_o
    input  mem_hier_pkg::word_t        addr_i,
    input  logic                       read_i,
    input  logic                       write_i,
    input  mem_hier_pkg::line_t        wdata_i,
    input  mem_hier_pkg::line_mask_t   mask_i,
    output mem_hier_pkg::line_t        rdata_o,
    output logic                       resp_o,

    // line port towards the arbiter
    output mem_hier_pkg::line_req_t    req_o,
    input  mem_hier_pkg::line_t        line_i,
    input  logic                       line_resp_i
);

    localparam int IDX_BITS = $clog2(SETS);
    localparam int TAG_BITS = 32 - mem_hier_pkg::OFFSET_BITS - IDX_BITS;
    localparam int LINE_BYTES = $bits(mem_hier_pkg::line_mask_t);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_FILL
    } state_e;

    state_e state_q;

    // per-set arrays
    logic [SETS-1:0]        valid_q;
    logic [SETS-1:0]        dirty_q;
    logic [TAG_BITS-1:0]    tag_q [SETS];
    mem_hier_pkg::line_t    data_q [SETS];

    logic [IDX_BITS-1:0]    idx;
    logic [TAG_BITS-1:0]    tag;
    logic                   hit;
    logic                   wr_en;

    assign idx = addr_i[mem_hier_pkg::OFFSET_BITS +: IDX_BITS];
    assign tag = addr_i[31 -: TAG_BITS];
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    // instruction side never stores
    assign wr_en = (WRITABLE != 0) && write_i;

    assign rdata_o = data_q[idx];

    always_comb begin
        req_o.read  = (state_q == ST_FILL);
        req_o.write = (state_q == ST_WRITEBACK);
        req_o.wdata = data_q[idx];
        if (state_q == ST_WRITEBACK) begin
            req_o.addr = {tag_q[idx], idx, {mem_hier_pkg::OFFSET_BITS{1'b0}}}; // victim line
        end else begin
            req_o.addr = {tag, idx, {mem_hier_pkg::OFFSET_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            resp_o  <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            resp_o <= 1'b0;
            unique case (state_q)
                ST_IDLE: begin
                    // request is still held during the resp cycle, skip it
                    if ((read_i || wr_en) && !resp_o) begin
                        state_q <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (hit) begin
                        resp_o  <= 1'b1;
                        state_q <= ST_IDLE;
                        if (wr_en) begin
                            dirty_q[idx] <= 1'b1;
                        end
                    end else if ((WRITABLE != 0) && valid_q[idx] && dirty_q[idx]) begin
                        state_q <= ST_WRITEBACK;
                    end else begin
                        state_q <= ST_FILL;
                    end
                end
                ST_WRITEBACK: begin
                    if (line_resp_i) begin
                        dirty_q[idx] <= 1'b0;
                        state_q      <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (line_resp_i) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= ST_COMPARE;  // replay as a hit
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // line storage and tags
    always_ff @(posedge clk) begin
        if (state_q == ST_FILL && line_resp_i) begin
            data_q[idx] <= line_i;
            tag_q[idx]  <= tag;
        end else if (state_q == ST_COMPARE && hit && wr_en) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (mask_i[b]) begin
                    data_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule : line_cache

//--- verilog/mem_word_adapter.sv
`timescale 1ns/100ps

module mem_word_adapter (
    input  mem_hier_pkg::word_t      addr_i,
    input  mem_hier_pkg::line_t      line_rdata_i,
    input  mem_hier_pkg::word_t      wdata_i,
    input  mem_hier_pkg::byte_mask_t wmask_i,
    output mem_hier_pkg::word_t      rdata_o,
    output mem_hier_pkg::line_t      line_wdata_o,
    output mem_hier_pkg::line_mask_t line_mask_o
);

    localparam int SEL_BITS = mem_hier_pkg::OFFSET_BITS - 2;

    // word slot inside the line
    logic [SEL_BITS-1:0] word_sel;

    assign word_sel = addr_i[mem_hier_pkg::OFFSET_BITS-1:2];

    // pick the addressed word out of the line
    assign rdata_o = line_rdata_i[{word_sel, 5'b00000} +: 32];

    // the store word sits in every slot, the mask decides which one lands
    assign line_wdata_o = {8{wdata_i}};

    // 4 mask bits per word
    assign line_mask_o = mem_hier_pkg::line_mask_t'(wmask_i) << {word_sel, 2'b00};

endmodule : mem_word_adapter

//--- verilog/mem_hier_pkg.sv
package mem_hier_pkg;

    // line geometry
    parameter int OFFSET_BITS    = 5;   // 32 bytes per line
    parameter int BEATS_PER_LINE = 4;   // 64-bit beats on the memory side

    // address or data word
    typedef logic [31:0]  word_t;

    // byte enables of one word
    typedef logic [3:0]   byte_mask_t;

    // eight words
    typedef logic [255:0] line_t;

    // byte enables across a whole line
    typedef logic [31:0]  line_mask_t;

    // one memory beat
    typedef logic [63:0]  burst_t;

    // line transfer between a cache, the arbiter and the adaptor
    // read and write are never high together
    typedef struct packed {
        word_t addr;      // line aligned
        logic  read;
        logic  write;
        line_t wdata;     // only meaningful with write
    } line_req_t;

endpackage : mem_hier_pkg
